//--- Makefile
# Verilator build and run of the log meter testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_log_meter \
		-f filelist.f -o sim_tb

# Pass only when the testbench prints its pass line
run: compile
	@out="$$(./obj_dir/sim_tb +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf obj_dir

//--- credit_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module credit_fifo #(
  parameter type payload_t    = logic,
  parameter int  DEPTH        = 8,
  parameter int  SPACE_MARGIN = 1
) (
  input  logic     clk,
  input  logic     rst,

  // Write side
  input  logic     in_valid,
  input  payload_t in_data,

  // Read side
  input  logic     pop,
  output logic     out_valid,
  output payload_t out_data,

  // Flow control
  output logic     credit_ret,
  output logic     space
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Entry storage
  payload_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  ////////////////////
  // Status
  ////////////////////

  assign full      = (count == CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  // High while at least SPACE_MARGIN slots are free
  assign space = (CNT_W'(DEPTH) - count) >= CNT_W'(SPACE_MARGIN);

  // Only legal transfers move pointers
  assign do_push = in_valid && !full;
  assign do_pop  = pop && out_valid;

  ////////////////////
  // Pointers and count
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_ret <= 1'b0;
    end else begin
      // One credit back per entry leaving
      credit_ret <= do_pop;
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Write port
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

`default_nettype wire

//--- credit_sender.sv
`timescale 1ns/10ps
`default_nettype none

module credit_sender #(
  parameter int OUT_CREDITS = 2
) (
  input  logic          clk,
  input  logic          rst,

  // Output FIFO side
  input  logic          fifo_valid,
  input  log_pkg::log_t fifo_data,
  output logic          fifo_pop,

  // Downstream side
  input  logic          out_credit,
  output logic          out_valid,
  output log_pkg::log_t out_log
);

  localparam int CR_W = $clog2(OUT_CREDITS + 1);

  // Credits currently held toward downstream
  logic [CR_W-1:0] credits;

  // Send only against a credit in hand
  assign fifo_pop = fifo_valid && (credits != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      credits   <= CR_W'(OUT_CREDITS);
      out_valid <= 1'b0;
    end else begin
      out_valid <= fifo_pop;
      // Spend and return may land in the same cycle
      case ({fifo_pop, out_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Result register
  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      out_log <= fifo_data;
    end
  end

endmodule

`default_nettype wire

//--- energy_accum.sv
`timescale 1ns/10ps
`default_nettype none

module energy_accum #(
  parameter int WINDOW = 4
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         advance,

  // Sample side
  input  logic                         sample_valid,
  input  log_pkg::sample_t             sample_data,
  output logic                         sample_pop,

  // Energy side
  output logic                         energy_valid,
  output logic [log_pkg::ENERGY_W-1:0] energy
);

  localparam int SQ_W  = 2 * log_pkg::SAMPLE_W;
  localparam int EN_W  = log_pkg::ENERGY_W;
  localparam int CNT_W = (WINDOW > 1) ? $clog2(WINDOW) : 1;

  logic signed [SQ_W-1:0] sq_next;
  logic [SQ_W-1:0]        sq_reg;
  logic                   sq_valid;
  logic                   sq_last;
  logic [CNT_W-1:0]       cnt;
  logic [EN_W-1:0]        sum;
  logic [EN_W-1:0]        sum_next;

  // Take a sample only when the whole chain moves
  assign sample_pop = sample_valid && advance;

  // Signed square is never negative
  assign sq_next = sample_data * sample_data;

  // Zero-extended square onto the running sum
  assign sum_next = sum + {{(EN_W - SQ_W){1'b0}}, sq_reg};

  ////////////////////
  // Square stage
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      sq_valid <= 1'b0;
      sq_last  <= 1'b0;
      cnt      <= '0;
    end else if (advance) begin
      sq_valid <= sample_pop;
      if (sample_pop) begin
        // Mark the closing sample of a window
        sq_last <= (cnt == CNT_W'(WINDOW - 1));
        cnt     <= (cnt == CNT_W'(WINDOW - 1)) ? '0 : cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample_pop) begin
      sq_reg <= sq_next;
    end
  end

  ////////////////////
  // Sum stage
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      sum          <= '0;
      energy_valid <= 1'b0;
    end else if (advance) begin
      // Held through a stall so log2_pipe sees it on its next step
      energy_valid <= sq_valid && sq_last;
      if (sq_valid) begin
        // Restart from zero after the last square of a window
        sum <= sq_last ? '0 : sum_next;
      end
    end
  end

  // Window total
  always_ff @(posedge clk) begin
    if (advance && sq_valid && sq_last) begin
      energy <= sum_next;
    end
  end

endmodule

`default_nettype wire

//--- filelist.f
log_pkg.sv
credit_fifo.sv
energy_accum.sv
log2_pipe.sv
credit_sender.sv
log_meter_top.sv
log_meter_asserts.sv
tb_log_meter.sv

//--- log2_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module log2_pipe (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         advance,

  // Energy in
  input  logic                         energy_valid,
  input  logic [log_pkg::ENERGY_W-1:0] energy,

  // Log out in 6.4 fixed point
  output logic                         log_valid,
  output log_pkg::log_t                log_value
);

  localparam int EN_W  = log_pkg::ENERGY_W;
  localparam int INT_W = log_pkg::LOG_INT_W;
  localparam int IDX_W = log_pkg::LUT_IDX_W;
  // Bits below the top plus zero fill for short values
  localparam int EXT_W = EN_W - 1 + IDX_W;

  // Stage 1 outputs
  logic             s1_valid;
  logic [INT_W-1:0] s1_pos;
  logic [EN_W-2:0]  s1_low;

  // Stage 2 outputs
  logic             s2_valid;
  logic [INT_W-1:0] s2_pos;
  logic [IDX_W-1:0] s2_idx;

  // Combinational helpers
  logic [INT_W-1:0] lead_pos;
  logic [EXT_W-1:0] ext;
  logic [EXT_W-1:0] shifted;
  logic [INT_W-1:0] shamt;

  ////////////////////
  // Priority encoder
  ////////////////////

  // Highest set bit wins
  // Bit 0 alone and zero both give 0
  always_comb begin
    lead_pos = '0;
    for (int i = 1; i < EN_W; i++) begin
      if (energy[i]) begin
        lead_pos = INT_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= energy_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      s1_pos <= lead_pos;
      // The top bit is never below a leading one
      s1_low <= energy[EN_W-2:0];
    end
  end

  ////////////////////
  // Barrel shifter
  ////////////////////

  // Zeros appended so bits under bit 0 read as zero
  assign ext = {s1_low, {IDX_W{1'b0}}};

  // Move the bit just under the leading one to the top
  assign shamt   = INT_W'(EN_W - 1) - s1_pos;
  assign shifted = ext << shamt;

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_valid <= 1'b0;
    end else if (advance) begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      s2_pos <= s1_pos;
      s2_idx <= shifted[EXT_W-1 -: IDX_W];
    end
  end

  ////////////////////
  // Fraction lookup
  ////////////////////

  // Output valid is a strobe
  // The FIFO push does not look at advance so a held valid would repeat
  always_ff @(posedge clk) begin
    if (rst) begin
      log_valid <= 1'b0;
    end else begin
      log_valid <= advance && s2_valid;
    end
  end

  // Integer part above the table fraction
  always_ff @(posedge clk) begin
    if (advance) begin
      log_value <= {s2_pos, log_pkg::LOG_FRAC_LUT[s2_idx]};
    end
  end

endmodule

`default_nettype wire

//--- log_meter_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module log_meter_asserts #(
  parameter int IN_DEPTH    = 8,
  parameter int OUT_CREDITS = 2
) (
  input logic clk,
  input logic rst,
  input logic in_valid,
  input logic in_credit,
  input logic out_valid,
  input logic out_credit
);

  // Samples sent upstream and not yet returned as credits
  int in_outstanding;
  // Credits the top still holds toward downstream
  int out_avail;
  // Failure tally read by the testbench summary
  int fail_count = 0;

  ////////////////////
  // Credit shadows
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      in_outstanding <= 0;
      out_avail      <= OUT_CREDITS;
    end else begin
      in_outstanding <= in_outstanding + int'(in_valid) - int'(in_credit);
      out_avail      <= out_avail - int'(out_valid) + int'(out_credit);
    end
  end

  ////////////////////
  // Flow control
  ////////////////////

  // Every result spends a credit already held
  a_out_credit: assert property (
    @(posedge clk) disable iff (rst) out_valid |-> (out_avail > 0)
  ) else begin
    $error("out_valid raised with no downstream credit held");
    fail_count++;
  end

  // Upstream never overfills the sample FIFO
  a_in_room: assert property (
    @(posedge clk) disable iff (rst) in_valid |-> (in_outstanding < IN_DEPTH)
  ) else begin
    $error("in_valid raised while the input FIFO could be full");
    fail_count++;
  end

  // No credit returned for a sample never accepted
  a_in_return: assert property (
    @(posedge clk) disable iff (rst) in_credit |-> (in_outstanding > 0)
  ) else begin
    $error("in_credit returned more credits than samples accepted");
    fail_count++;
  end

  // Quiet outputs right after reset
  a_reset_quiet: assert property (
    @(posedge clk) rst |=> (!in_credit && !out_valid)
  ) else begin
    $error("in_credit or out_valid high after reset");
    fail_count++;
  end

endmodule

bind log_meter_top log_meter_asserts #(
  .IN_DEPTH    (IN_DEPTH),
  .OUT_CREDITS (OUT_CREDITS)
) u_asserts (
  .clk        (clk),
  .rst        (rst),
  .in_valid   (in_valid),
  .in_credit  (in_credit),
  .out_valid  (out_valid),
  .out_credit (out_credit)
);

`default_nettype wire

//--- log_meter_top.sv
`timescale 1ns/10ps
`default_nettype none

module log_meter_top #(
  parameter int WINDOW      = 4,
  parameter int IN_DEPTH    = 8,
  parameter int OUT_DEPTH   = 8,
  parameter int OUT_CREDITS = 2
) (
  input  logic             clk,
  input  logic             rst,

  // Upstream
  input  logic             in_valid,
  input  log_pkg::sample_t in_sample,
  output logic             in_credit,

  // Downstream
  output logic             out_valid,
  output log_pkg::log_t    out_log,
  input  logic             out_credit
);

  // Sample FIFO to accumulator
  logic                         sample_valid;
  log_pkg::sample_t             sample_data;
  logic                         sample_pop;

  // Accumulator to logarithm
  logic                         energy_valid;
  logic [log_pkg::ENERGY_W-1:0] energy;

  // Logarithm to result FIFO
  logic                         log_valid;
  log_pkg::log_t                log_value;

  // Result FIFO to sender
  logic                         res_valid;
  log_pkg::log_t                res_data;
  logic                         res_pop;

  // Shared stall for accumulator and pipeline
  logic                         advance;

  ////////////////////
  // Input side
  ////////////////////

  // Each pop returns one upstream credit
  credit_fifo #(
    .payload_t    (log_pkg::sample_t),
    .DEPTH        (IN_DEPTH),
    .SPACE_MARGIN (1)
  ) u_in_fifo (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_data    (in_sample),
    .pop        (sample_pop),
    .out_valid  (sample_valid),
    .out_data   (sample_data),
    .credit_ret (in_credit),
    .space      ()
  );

  energy_accum #(
    .WINDOW (WINDOW)
  ) u_accum (
    .clk          (clk),
    .rst          (rst),
    .advance      (advance),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .sample_pop   (sample_pop),
    .energy_valid (energy_valid),
    .energy       (energy)
  );

  log2_pipe u_log2 (
    .clk          (clk),
    .rst          (rst),
    .advance      (advance),
    .energy_valid (energy_valid),
    .energy       (energy),
    .log_valid    (log_valid),
    .log_value    (log_value)
  );

  ////////////////////
  // Output side
  ////////////////////

  // Margin covers three pipe stages plus the pending window total
  credit_fifo #(
    .payload_t    (log_pkg::log_t),
    .DEPTH        (OUT_DEPTH),
    .SPACE_MARGIN (4)
  ) u_out_fifo (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (log_valid),
    .in_data    (log_value),
    .pop        (res_pop),
    .out_valid  (res_valid),
    .out_data   (res_data),
    .credit_ret (),
    .space      (advance)
  );

  credit_sender #(
    .OUT_CREDITS (OUT_CREDITS)
  ) u_sender (
    .clk        (clk),
    .rst        (rst),
    .fifo_valid (res_valid),
    .fifo_data  (res_data),
    .fifo_pop   (res_pop),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_log    (out_log)
  );

endmodule

`default_nettype wire

//--- log_pkg.sv
`default_nettype none

package log_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Input sample width
  localparam int SAMPLE_W = 16;
  // Sum of squares over one window
  localparam int ENERGY_W = 64;

  // Log result in 6.4 fixed point
  localparam int LOG_INT_W  = 6;
  localparam int LOG_FRAC_W = 4;
  localparam int LOG_W      = LOG_INT_W + LOG_FRAC_W;

  // Fraction table geometry
  localparam int LUT_IDX_W = 5;
  localparam int LUT_DEPTH = 1 << LUT_IDX_W;

  ////////////////////
  // Payload types
  ////////////////////

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic [LOG_W-1:0] log_t;

  ////////////////////
  // Fraction table
  ////////////////////

  // Round(16 * log2(1 + i/32)) indexed by the bits below the leading one
  // Entry 28 held at 14 to keep the curve smooth
  localparam logic [LOG_FRAC_W-1:0] LOG_FRAC_LUT [LUT_DEPTH] = '{
    4'd0,  4'd1,  4'd1,  4'd2,  4'd3,  4'd3,  4'd4,  4'd5,
    4'd5,  4'd6,  4'd6,  4'd7,  4'd7,  4'd8,  4'd8,  4'd9,
    4'd9,  4'd10, 4'd10, 4'd11, 4'd11, 4'd12, 4'd12, 4'd13,
    4'd13, 4'd13, 4'd14, 4'd14, 4'd14, 4'd15, 4'd15, 4'd15
  };

endpackage

`default_nettype wire

//--- tb_log_meter.sv
`timescale 1ns/10ps
`default_nettype none

module tb_log_meter;

  localparam int WINDOW      = 4;
  localparam int IN_DEPTH    = 8;
  localparam int OUT_DEPTH   = 8;
  localparam int OUT_CREDITS = 2;
  localparam int EN_W        = log_pkg::ENERGY_W;
  localparam int IDX_W       = log_pkg::LUT_IDX_W;

  // Samples per test in whole windows
  localparam int N_CONST       = 12;
  localparam int N_EDGE        = 16;
  localparam int N_RANDOM      = 80;
  localparam int N_BACKPR      = 40;
  localparam int TOTAL_SAMPLES = N_CONST + N_EDGE + N_RANDOM + N_BACKPR;

  // Zero, unit, full-scale negative, full-scale mixed
  localparam log_pkg::sample_t EDGE_VALS [N_EDGE] = '{
    16'sh0000, 16'sh0000, 16'sh0000, 16'sh0000,
    16'sh0001, 16'shffff, 16'sh0001, 16'shffff,
    16'sh8000, 16'sh8000, 16'sh8000, 16'sh8000,
    16'sh8000, 16'sh7fff, 16'sh8000, 16'sh7fff
  };

  logic             clk = 1'b0;
  logic             rst;
  logic             in_valid;
  log_pkg::sample_t in_sample;
  logic             in_credit;
  logic             out_valid;
  log_pkg::log_t    out_log;
  logic             out_credit;

  // Upstream and downstream models
  int               up_credits;
  int               credit_pulses;
  int               samples_sent = 0;
  int               pending;
  logic             hold = 1'b0;

  // Window model and expected results
  logic [EN_W-1:0]  win_sum = '0;
  int               win_cnt = 0;
  log_pkg::log_t    exp_q [$];

  // Bookkeeping
  string            cur_test = "reset";
  int               errors = 0;
  int               passed = 0;
  int               failed = 0;
  int               errs_at_start;

  log_meter_top #(
    .WINDOW      (WINDOW),
    .IN_DEPTH    (IN_DEPTH),
    .OUT_DEPTH   (OUT_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) uut (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_sample  (in_sample),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_log    (out_log),
    .out_credit (out_credit)
  );

  always #5 clk = ~clk;

  ////////////////////
  // Reference model
  ////////////////////

  // Leading one gives the integer part
  // Five bits under it index the table
  function automatic log_pkg::log_t expected_log(input logic [EN_W-1:0] e);
    int                    pos;
    logic [EN_W+IDX_W-1:0] ext;
    logic [IDX_W-1:0]      idx;
    if (e < 2) begin
      return '0;
    end
    pos = 0;
    for (int i = 0; i < EN_W; i++) begin
      if (e[i]) begin
        pos = i;
      end
    end
    // Bits missing under bit 0 read as zero
    ext = {e, {IDX_W{1'b0}}};
    idx = ext[pos +: IDX_W];
    return {6'(pos), log_pkg::LOG_FRAC_LUT[idx]};
  endfunction

  function automatic log_pkg::sample_t random_sample();
    // Random magnitude spread so leading-one positions vary
    return log_pkg::sample_t'($urandom) >>> $urandom_range(12, 0);
  endfunction

  task automatic check_value(input string what, input int exp, input int act);
    assert (exp == act) else begin
      $display("FAILED %s: expected %0d, actual %0d", what, exp, act);
      errors++;
    end
  endtask

  ////////////////////
  // Upstream side
  ////////////////////

  // Credits spent on send and returned by in_credit
  always @(posedge clk) begin
    if (rst) begin
      up_credits    <= IN_DEPTH;
      credit_pulses <= 0;
    end else begin
      up_credits <= up_credits - int'(in_valid) + int'(in_credit);
      if (in_credit) begin
        credit_pulses <= credit_pulses + 1;
      end
    end
  end

  // Called on a falling edge and returns on one
  task automatic send_sample(input log_pkg::sample_t s, input int max_gap);
    int gap;
    gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
    repeat (gap) @(negedge clk);
    while (up_credits == 0) begin
      @(negedge clk);
    end
    in_valid  = 1'b1;
    in_sample = s;
    samples_sent++;
    // Sum of squares with one expected log per full window
    win_sum = win_sum + 64'(longint'(s) * longint'(s));
    win_cnt++;
    if (win_cnt == WINDOW) begin
      exp_q.push_back(expected_log(win_sum));
      win_sum = '0;
      win_cnt = 0;
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  ////////////////////
  // Downstream side
  ////////////////////

  // Each result checked against the queue head
  // Credit given back unless held
  initial begin
    out_credit = 1'b0;
    pending    = 0;
    forever begin
      @(negedge clk);
      if (!rst && out_valid) begin
        if (exp_q.size() == 0) begin
          $display("Result %0d arrived in %s with no window outstanding", out_log, cur_test);
          errors++;
        end else begin
          check_value(cur_test, int'(exp_q[0]), int'(out_log));
          exp_q.delete(0);
        end
        pending++;
      end
      if (!hold && pending > 0) begin
        out_credit = 1'b1;
        pending--;
      end else begin
        out_credit = 1'b0;
      end
    end
  end

  ////////////////////
  // Test sequencing
  ////////////////////

  task automatic start_test(input string name);
    cur_test      = name;
    errs_at_start = errors + uut.u_asserts.fail_count;
  endtask

  task automatic finish_test();
    int n;
    int errs;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    // Let the last credit returns land
    n = 0;
    while (up_credits != IN_DEPTH && n < 20) begin
      @(negedge clk);
      n++;
    end
    check_value({cur_test, " idle credits"}, IN_DEPTH, up_credits);
    check_value({cur_test, " credit total"}, samples_sent, credit_pulses);
    errs = errors + uut.u_asserts.fail_count - errs_at_start;
    if (errs == 0) begin
      $display("test %s: ok", cur_test);
      passed++;
    end else begin
      $display("test %s: %0d failures", cur_test, errs);
      failed++;
    end
  endtask

  // Watchdog sized from the sample count
  initial begin
    repeat (TOTAL_SAMPLES * 50) @(posedge clk);
    $display("Watchdog expired in %s before the tests finished", cur_test);
    $display("sim failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h72ba825a));
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_sample = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Constant amplitude with alternating sign
    start_test("constant");
    check_value("model 4e6 integer part", 21, int'(expected_log(64'd4000000) >> 4));
    for (int i = 0; i < N_CONST; i++) begin
      send_sample((i % 2 == 1) ? -16'sd1000 : 16'sd1000, 0);
    end
    finish_test();

    // Zero, energy 4, full scale
    start_test("edge");
    check_value("model energy 4", 32, int'(expected_log(64'd4)));
    for (int i = 0; i < N_EDGE; i++) begin
      send_sample(EDGE_VALS[i], 1);
    end
    finish_test();

    // Random values with random gaps
    start_test("random");
    for (int i = 0; i < N_RANDOM; i++) begin
      send_sample(random_sample(), 3);
    end
    finish_test();

    // Long credit droughts on the output
    start_test("backpressure");
    fork
      begin
        for (int i = 0; i < N_BACKPR; i++) begin
          send_sample(random_sample(), 0);
        end
      end
      begin
        hold = 1'b1;
        repeat (300) @(negedge clk);
        hold = 1'b0;
        repeat (12) @(negedge clk);
        hold = 1'b1;
        repeat (200) @(negedge clk);
        hold = 1'b0;
      end
    join
    finish_test();

    $display("%0d tests passed, %0d tests failed", passed, failed);
    if (failed == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
